// ==== tb.f ====
+incdir+source
source/audio_sample_pkg.sv
source/i2s_frame_pkg.sv
source/sample_fifo.sv
source/i2s_clock_gen.sv
source/i2s_serializer.sv
source/audio_i2s_top.sv
verif/tb_audio_i2s.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the I2S transmitter testbench with Verilator and run it.
# Exit status is non-zero when the simulation fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -j 0 \
    --top-module tb_audio_i2s \
    -f tb.f \
    -o sim_tb_audio_i2s

./obj_dir/sim_tb_audio_i2s

// ==== verif/tb_audio_i2s.sv ====
// Testbench for the I2S stereo transmitter.
// Sends random stereo pairs with random gaps, a back-pressure phase and a
// drain phase. A model of the frame timing predicts sclk, lrck, underrun and
// sample_ready, and dac is decoded at sclk rises and compared with the queue.

`timescale 1ns/100ps
`include "audio_cfg.svh"

module tb_audio_i2s;

    localparam int SEED        = 92093;
    localparam int N_PAIRS     = 24;
    localparam int FRAME_CYC   = 256;
    localparam int CYCLE_LIMIT = (N_PAIRS + 8) * FRAME_CYC;
    localparam int SW          = `AUDIO_SAMPLE_BITS;
    localparam int SLOT        = `AUDIO_SLOT_BITS;
    localparam int DIV         = `AUDIO_SCLK_DIV;

    logic                           audgen_mclk;
    logic                           reset_n;
    logic                           sample_valid;
    audio_sample_pkg::stereo_pair_t sample_data;
    logic                           sample_ready;
    logic                           sclk;
    logic                           lrck;
    logic                           dac;
    logic                           underrun;

    // model state
    audio_sample_pkg::stereo_pair_t pair_q [$];
    audio_sample_pkg::sample_t      exp_left;
    audio_sample_pkg::sample_t      exp_right;
    audio_sample_pkg::sample_t      got_acc;
    logic                           exp_underrun;
    logic                           frame_has_data;
    logic                           dac_prev;
    logic                           bp_seen;
    int                             cyc;
    int                             pairs_checked;

    audio_i2s_top dut (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .sclk         (sclk),
        .lrck         (lrck),
        .dac          (dac),
        .underrun     (underrun)
    );

    initial begin
        audgen_mclk = 1'b0;
        forever #2 audgen_mclk = ~audgen_mclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_sample(input string name, input audio_sample_pkg::sample_t got,
                                input audio_sample_pkg::sample_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "sample mismatch at cycle %0d", cyc);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "flag mismatch at cycle %0d", cyc);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "serial bit mismatch at cycle %0d", cyc);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // model of the frame timing

    // one dac bit per sclk rise
    // f counts the sclk falls so far
    task automatic decode_dac_bit(input int f);
        int p;
        int slot_pos;
        if (f == 0) begin
            check_bit("dac", dac, 1'b0);
        end else begin
            p        = (f - 1) % (2 * SLOT);
            slot_pos = p % SLOT;
            if (slot_pos < SW) begin
                got_acc = {got_acc[SW-2:0], dac};
                if (slot_pos == SW - 1) begin
                    if (p < SLOT) begin
                        check_sample("dac_left", got_acc, exp_left);
                    end else begin
                        check_sample("dac_right", got_acc, exp_right);
                        if (frame_has_data) begin
                            pairs_checked = pairs_checked + 1;
                        end
                    end
                end
            end else begin
                check_bit("dac_pad", dac, 1'b0);
            end
        end
    endtask

    // state after edge cyc as seen mid-cycle
    task automatic check_outputs();
        int   f;
        logic exp_lrck;
        f = cyc / DIV;
        if (f == 0) begin
            exp_lrck = 1'b0;
        end else begin
            exp_lrck = ((f - 1) % (2 * SLOT)) >= SLOT;
        end
        check_flag("sclk", sclk, (cyc % DIV) >= DIV / 2);
        check_flag("lrck", lrck, exp_lrck);
        check_flag("underrun", underrun, exp_underrun);
        check_flag("sample_ready", sample_ready, pair_q.size() < `AUDIO_FIFO_DEPTH);
        if (!sample_ready) begin
            bp_seen = 1'b1;
        end
        // dac only moves on sclk falls
        if ((cyc % DIV) != 0) begin
            check_bit("dac", dac, dac_prev);
        end
        dac_prev = dac;
        if ((cyc % DIV) == DIV / 2) begin
            decode_dac_bit(f);
        end
    endtask

    // pop before push
    // a pair pushed at a frame edge waits a frame
    task automatic advance_model();
        int                             k;
        int                             f;
        audio_sample_pkg::stereo_pair_t pair;
        k = cyc + 1;
        if ((k % DIV) == 0) begin
            f = k / DIV;
            if (((f - 1) % (2 * SLOT)) == 0) begin
                if (pair_q.size() > 0) begin
                    pair           = pair_q.pop_front();
                    exp_left       = pair[2*SW-1:SW];
                    exp_right      = pair[SW-1:0];
                    frame_has_data = 1'b1;
                end else begin
                    exp_left       = '0;
                    exp_right      = '0;
                    frame_has_data = 1'b0;
                    exp_underrun   = 1'b1;
                end
            end
        end
        if (sample_valid && sample_ready) begin
            pair_q.push_back(sample_data);
        end
    endtask

    always @(negedge audgen_mclk) begin
        if (reset_n) begin
            if (cyc >= CYCLE_LIMIT) begin
                $display("Test FAILED");
                $fatal(1, "timeout, %0d of %0d pairs came out within %0d cycles",
                       pairs_checked, N_PAIRS, cyc);
            end else begin
                check_outputs();
                advance_model();
                cyc = cyc + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge audgen_mclk);
            #0.5;
        end
    endtask

    // entered and left 0.5 ns after a rising edge
    task automatic send_pair(input int gap);
        logic accepted;
        wait_cycles(gap);
        sample_valid = 1'b1;
        sample_data  = $urandom;
        accepted     = 1'b0;
        while (!accepted) begin
            accepted = sample_ready;
            wait_cycles(1);
        end
        sample_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        reset_n        = 1'b0;
        sample_valid   = 1'b0;
        sample_data    = '0;
        exp_left       = '0;
        exp_right      = '0;
        got_acc        = '0;
        exp_underrun   = 1'b0;
        frame_has_data = 1'b0;
        dac_prev       = 1'b0;
        bp_seen        = 1'b0;
        cyc            = 0;
        pairs_checked  = 0;

        repeat (3) @(posedge audgen_mclk);
        #0.5;
        check_flag("sclk", sclk, 1'b0);
        check_flag("lrck", lrck, 1'b0);
        check_bit("dac", dac, 1'b0);
        check_flag("underrun", underrun, 1'b0);
        check_flag("sample_ready", sample_ready, 1'b1);
        reset_n = 1'b1;

        // valid held high until the fifo pushes back
        repeat (10) send_pair(0);
        // gaps shorter than a frame keep the fifo fed
        repeat (8) send_pair($urandom_range(0, 200));
        // stop long enough for a silent frame
        wait_cycles(6 * FRAME_CYC);
        // resume after the underrun
        repeat (6) send_pair($urandom_range(0, 300));

        wait (pairs_checked == N_PAIRS);
        wait_cycles(1);
        check_flag("underrun", underrun, 1'b1);
        check_flag("backpressure_seen", bp_seen, 1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== source/audio_i2s_top.sv ====
// Stereo I2S transmitter on the master audio clock.
// Samples arrive as left/right pairs on a valid/ready stream and leave
// as sclk, lrck and dac. underrun latches on the first silent frame.

`timescale 1ns/100ps

module audio_i2s_top (
    input  logic                           audgen_mclk,
    input  logic                           reset_n,
    // sample stream in
    input  logic                           sample_valid,
    input  audio_sample_pkg::stereo_pair_t sample_data,
    output logic                           sample_ready,
    // i2s out
    output logic                           sclk,
    output logic                           lrck,
    output logic                           dac,
    // status
    output logic                           underrun
);

    ////////////////////////////////////////////////////////////////////////
    // internal wires

    logic                           sclk_fall;
    logic                           frame_start;
    logic                           pop;
    logic                           pair_avail;
    audio_sample_pkg::stereo_pair_t pair_data;

    ////////////////////////////////////////////////////////////////////////
    // sample buffer

    sample_fifo u_fifo (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .pop          (pop),
        .pair_avail   (pair_avail),
        .pair_data    (pair_data)
    );

    // bit clock and word select
    i2s_clock_gen u_clk (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sclk        (sclk),
        .lrck        (lrck),
        .sclk_fall   (sclk_fall),
        .frame_start (frame_start)
    );

    // data shifter
    i2s_serializer u_ser (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sclk_fall   (sclk_fall),
        .frame_start (frame_start),
        .pop         (pop),
        .pair_avail  (pair_avail),
        .pair_data   (pair_data),
        .dac         (dac),
        .underrun    (underrun)
    );

endmodule

// ==== source/i2s_serializer.sv ====
// Serial data side of the I2S transmitter.
// Loads one stereo pair per frame and shifts each sample MSB first
// on sclk falls, padding every slot with zeros.
// An empty FIFO at a frame start sends silence and sets underrun.

`timescale 1ns/100ps
`include "audio_cfg.svh"

module i2s_serializer (
    input  logic                           audgen_mclk,
    input  logic                           reset_n,
    input  logic                           sclk_fall,
    input  logic                           frame_start,
    output logic                           pop,
    input  logic                           pair_avail,
    input  audio_sample_pkg::stereo_pair_t pair_data,
    output logic                           dac,
    output logic                           underrun
);

    localparam int SW = `AUDIO_SAMPLE_BITS;

    i2s_frame_pkg::ser_state_t state;
    i2s_frame_pkg::slot_bit_t  bit_cnt;
    logic                      right_slot;
    logic                      data_last;
    logic                      slot_last;

    // payload, loaded at frame start only
    audio_sample_pkg::sample_t shift_reg;
    audio_sample_pkg::sample_t right_hold;
    audio_sample_pkg::sample_t left_in;
    audio_sample_pkg::sample_t right_in;

    // fifo head is read in the same cycle as the request
    assign pop = frame_start;

    // zeros when nothing is queued
    assign left_in  = pair_avail ? pair_data[2*SW-1:SW] : '0;
    assign right_in = pair_avail ? pair_data[SW-1:0]    : '0;

    assign data_last = (bit_cnt == i2s_frame_pkg::slot_bit_t'(SW-1));
    assign slot_last = (bit_cnt == i2s_frame_pkg::slot_bit_t'(`AUDIO_SLOT_BITS-1));

    ////////////////////////////////////////////////////////////////////////
    // payload registers

    always_ff @(posedge audgen_mclk) begin
        if (frame_start) begin
            shift_reg  <= left_in;
            right_hold <= right_in;
        end else if (sclk_fall) begin
            if (state == i2s_frame_pkg::SER_DATA) begin
                shift_reg <= {shift_reg[SW-2:0], 1'b0};
            end else if (state == i2s_frame_pkg::SER_PAD && slot_last && !right_slot) begin
                // right sample takes over for the second slot
                shift_reg <= right_hold;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // fsm, bit counter and dac

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= i2s_frame_pkg::SER_IDLE;
            bit_cnt    <= '0;
            right_slot <= 1'b0;
            dac        <= 1'b0;
            underrun   <= 1'b0;
        end else if (frame_start) begin
            // left msb goes out with the lrck change
            state      <= i2s_frame_pkg::SER_DATA;
            bit_cnt    <= '0;
            right_slot <= 1'b0;
            dac        <= left_in[SW-1];
            if (!pair_avail) begin
                underrun <= 1'b1;
            end
        end else if (sclk_fall) begin
            case (state)
                i2s_frame_pkg::SER_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (data_last) begin
                        state <= i2s_frame_pkg::SER_PAD;
                        dac   <= 1'b0;
                    end else begin
                        // next bit down
                        dac <= shift_reg[SW-2];
                    end
                end
                i2s_frame_pkg::SER_PAD: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    dac     <= 1'b0;
                    if (slot_last) begin
                        if (!right_slot) begin
                            state      <= i2s_frame_pkg::SER_DATA;
                            right_slot <= 1'b1;
                            dac        <= right_hold[SW-1];
                        end else begin
                            // normally preempted by frame_start
                            state <= i2s_frame_pkg::SER_IDLE;
                        end
                    end
                end
                default: begin
                    // waiting for the first frame
                    dac <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== source/i2s_clock_gen.sv ====
// Bit clock and word select timing for the I2S transmitter.
// Divides mclk by four into sclk, counts 32 sclk periods per slot and
// toggles lrck. Strobes tell the serializer when sclk falls and when
// a new frame begins.

`timescale 1ns/100ps
`include "audio_cfg.svh"

module i2s_clock_gen (
    input  logic audgen_mclk,
    input  logic reset_n,
    output logic sclk,
    output logic lrck,
    output logic sclk_fall,
    output logic frame_start
);

    ////////////////////////////////////////////////////////////////////////
    // sclk divider

    i2s_frame_pkg::sclk_div_t div_cnt;

    // sclk high for the upper half of the count
    assign sclk = div_cnt[$bits(i2s_frame_pkg::sclk_div_t)-1];

    // last mclk of an sclk period, sclk drops at the next edge
    assign sclk_fall = (div_cnt == i2s_frame_pkg::sclk_div_t'(`AUDIO_SCLK_DIV-1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // slot bit counter and lrck

    i2s_frame_pkg::slot_bit_t bit_cnt;
    logic                     running;
    logic                     slot_last;

    assign slot_last = (bit_cnt == i2s_frame_pkg::slot_bit_t'(`AUDIO_SLOT_BITS-1));

    // first fall after reset opens the left slot without a toggle
    // after that a frame starts where the right slot wraps
    assign frame_start = sclk_fall & (~running | (slot_last & lrck));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            running <= 1'b0;
            bit_cnt <= '0;
            lrck    <= 1'b0;
        end else if (sclk_fall) begin
            if (!running) begin
                // lrck already low for left
                running <= 1'b1;
                bit_cnt <= '0;
            end else begin
                // wraps to bit 0 of the next slot
                bit_cnt <= bit_cnt + 1'b1;
                if (slot_last) begin
                    lrck <= ~lrck;
                end
            end
        end
    end

endmodule

// ==== source/sample_fifo.sv ====
// Small FIFO of stereo pairs in front of the serializer.
// Filled through a valid/ready stream, drained one pair per frame by pop.
// Head pair is visible combinationally as pair_data while pair_avail is high.

`timescale 1ns/100ps
`include "audio_cfg.svh"

module sample_fifo (
    input  logic                         audgen_mclk,
    input  logic                         reset_n,
    // input stream
    input  logic                         sample_valid,
    input  audio_sample_pkg::stereo_pair_t sample_data,
    output logic                         sample_ready,
    // serializer side
    input  logic                         pop,
    output logic                         pair_avail,
    output audio_sample_pkg::stereo_pair_t pair_data
);

    localparam int ADDR_BITS = $clog2(`AUDIO_FIFO_DEPTH);

    ////////////////////////////////////////////////////////////////////////
    // storage and pointers

    audio_sample_pkg::stereo_pair_t mem [`AUDIO_FIFO_DEPTH];

    audio_sample_pkg::fifo_ptr_t wr_ptr;
    audio_sample_pkg::fifo_ptr_t rd_ptr;

    logic full;
    logic empty;
    logic push_en;
    logic pop_en;

    // same index, wrap bits apart means a full lap ahead
    assign full  = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
                   (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    // back-pressure only when full, independent of pop
    assign sample_ready = ~full;

    // transfer on valid and ready
    assign push_en = sample_valid & sample_ready;

    // pop on empty is ignored, serializer sees pair_avail low
    assign pop_en = pop & ~empty;

    ////////////////////////////////////////////////////////////////////////
    // head of queue

    assign pair_avail = ~empty;
    assign pair_data  = mem[rd_ptr[ADDR_BITS-1:0]];

    ////////////////////////////////////////////////////////////////////////
    // write side

    // pair lands at the transfer edge
    // a pop at that same edge still sees the old head
    always_ff @(posedge audgen_mclk) begin
        if (push_en) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= sample_data;
        end
    end

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
        end else if (push_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // read side

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
        end else if (pop_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== source/i2s_frame_pkg.sv ====
// Types for the I2S frame timing and the serializer.
// Used by the clock generator and the serializer.

`include "audio_cfg.svh"

package i2s_frame_pkg;

    ////////////////////////////////////////////////////////////////////////
    // counters

    // sclk period within one channel slot, 0 to 31
    typedef logic [$clog2(`AUDIO_SLOT_BITS)-1:0] slot_bit_t;

    // mclk count within one sclk period
    // top bit doubles as sclk
    typedef logic [$clog2(`AUDIO_SCLK_DIV)-1:0] sclk_div_t;

    ////////////////////////////////////////////////////////////////////////
    // serializer fsm

    // idle until the first frame, then data and pad alternate
    // twice per frame
    typedef enum logic [1:0] {
        SER_IDLE,
        SER_DATA,
        SER_PAD
    } ser_state_t;

endpackage

// ==== source/audio_sample_pkg.sv ====
// Types for audio samples as they enter the transmitter.
// Used by the sample FIFO, the serializer and the top level.

`include "audio_cfg.svh"

package audio_sample_pkg;

    // one channel sample, two's complement
    typedef logic signed [`AUDIO_SAMPLE_BITS-1:0] sample_t;

    // left in the upper half, right in the lower half
    typedef logic [2*`AUDIO_SAMPLE_BITS-1:0] stereo_pair_t;

    // fifo index plus one wrap bit
    // wrap bit differs and index equal means full
    typedef logic [$clog2(`AUDIO_FIFO_DEPTH):0] fifo_ptr_t;

endpackage

// ==== source/audio_cfg.svh ====
// Build-time sizes of the I2S audio output path.
// Included by the packages and by any module that needs a raw size.

`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// sample format

// bits per channel sample, shifted MSB first
`define AUDIO_SAMPLE_BITS 16

// sclk periods per channel slot
// the bits after the sample are sent as zeros
`define AUDIO_SLOT_BITS 32

////////////////////////////////////////////////////////////////////////////
// clocking

// mclk cycles per sclk period
// 12.288 MHz mclk gives a 3.072 MHz sclk
`define AUDIO_SCLK_DIV 4

////////////////////////////////////////////////////////////////////////////
// buffering

// stereo pairs held ahead of the serializer
// must be a power of two
`define AUDIO_FIFO_DEPTH 4

`endif
